// ==== design/ql_cfg_pkg.sv ====
// Step values and dividers assume an 84 MHz clk_sys; other clocks need new constants
package ql_cfg_pkg;

	// ==================================================
	// Configuration selects
	// ==================================================

	// CPU bus speed, QL is the original 7.5 MHz 68008 pace
	typedef enum logic [1:0]
	{
		speed_ql,
		speed_16m,
		speed_24m,
		speed_full
	} cpu_speed_e;

	// RAM fitted, 4096k also turns on the (Super)GoldCard map
	typedef enum logic [1:0]
	{
		ram_128k,
		ram_640k,
		ram_896k,
		ram_4096k
	} ram_cfg_e;

	// ==================================================
	// Clock enables
	// ==================================================

	localparam int FRACT_WIDTH = 16;                          // Bus accumulator width

	// Step per clk_sys, tick rate = 84 MHz * step / 65536
	localparam logic [FRACT_WIDTH:0] FRACT_BUS_QL   = 17'd11702;  // ~15 MHz
	localparam logic [FRACT_WIDTH:0] FRACT_BUS_16   = 17'd24966;  // ~32 MHz
	localparam logic [FRACT_WIDTH:0] FRACT_BUS_24   = 17'd37449;  // 48 MHz
	localparam logic [FRACT_WIDTH:0] FRACT_BUS_FULL = 17'd65536;  // Carry every cycle

	localparam int unsigned DIV_131K = 640;                   // 131.25 kHz refresh and RTC tick
	localparam int unsigned DIV_VID  = 8;                     // 10.5 MHz pixel tick

	// Core reset length in ce_bus_p pulses
	localparam int unsigned RESET_HOLD = 4095;

	// ==================================================
	// Memory map
	// ==================================================

	localparam logic [23:0] MASK_256K = 24'h03ffff;           // 128k, wraps at 256 KB
	localparam logic [23:0] MASK_1M   = 24'h0fffff;           // 640k and 896k
	localparam logic [23:0] MASK_8M   = 24'h7fffff;           // 4 MB RAM plus GoldCard space

	// GoldCard register offsets within $1c0xx
	localparam logic [7:0] GC_SHADOW_ON_OFS  = 8'h60;         // glo_rena
	localparam logic [7:0] GC_SHADOW_OFF_OFS = 8'h64;         // glo_rdis

	localparam logic [15:0] FILL_WORD = 16'hffff;             // Unmapped reads float high

endpackage

// ==== design/ql_bus_pkg.sv ====
// Cycle signals are active high here; the CPU wrapper inverts the 68000 strobes
package ql_bus_pkg;

	// ==================================================
	// CPU side
	// ==================================================

	// One 68000 bus cycle, held by the CPU until dtack
	typedef struct packed
	{
		logic        as;         // Address strobe
		logic        rw;         // 1 read, 0 write
		logic        uds;        // Upper byte, even address
		logic        lds;        // Lower byte, odd address
		logic [22:0] addr;       // A23..A1
		logic [15:0] wdata;
	} cpu_cycle_t;

	// Data returned by memories and peripherals outside the glue
	typedef struct packed
	{
		logic [15:0] sdram_dout;
		logic        sdram_dtack; // Low while the SDRAM stalls
		logic [15:0] ql_rom_dout; // OS plus extension ROM
		logic [15:0] gc_rom_dout; // GoldCard boot ROM
		logic [15:0] io_dout;     // ZX8302 and mouse read data
	} mem_rsp_t;

	// ==================================================
	// Memory side
	// ==================================================

	typedef struct packed
	{
		logic [23:0] sdram_addr;  // Word address
		logic        sdram_wr;
		logic        sdram_oe;
		logic        vram_wr;     // Screen RAM at $02xxxx
		logic        zx8302_sel;
		logic        sdram_uds;
		logic        sdram_lds;
	} mem_req_t;

	// Decoded view of the current cycle
	typedef struct packed
	{
		logic        rd;          // Valid read, some strobe set
		logic        wr;          // Valid write
		logic        ql_io;       // $18000-$1bfff
		logic        ram;         // Any RAM incl. GoldCard extras
		logic        rom;         // $00xxxx
		logic        os_rom;      // $0000-$bfff
		logic        ext_rom;     // $c000-$ffff
		logic        gc_io;       // $1c000-$1c0ff
		logic        gc_boot_rom; // $04xxxx
		logic        gc_os_rom;   // $40xxxx
		logic [23:0] addr;        // Masked byte address
	} region_t;

endpackage

// ==== design/ql_clock_enables.sv ====
// Enables are one clk_sys wide; a speed change takes effect on the next accumulator step
module ql_clock_enables
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_cfg_pkg::cpu_speed_e cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid
);

	localparam int FW       = ql_cfg_pkg::FRACT_WIDTH;
	localparam int DIV131_W = $clog2(ql_cfg_pkg::DIV_131K);
	localparam int DIVVID_W = $clog2(ql_cfg_pkg::DIV_VID);

	logic [FW:0]         fract_step;
	logic [FW-1:0]       cnt_bus;     // Fractional accumulator
	logic                bus_tick;    // Carry out, one per bus phase
	logic                bus_pol;     // 0 next tick is p, 1 next is n
	logic [DIV131_W-1:0] div_131k;
	logic [DIVVID_W-1:0] div_vid;

	// Step select
	always_comb
	begin
		case (cpu_speed)
			ql_cfg_pkg::speed_ql:  fract_step = ql_cfg_pkg::FRACT_BUS_QL;
			ql_cfg_pkg::speed_16m: fract_step = ql_cfg_pkg::FRACT_BUS_16;
			ql_cfg_pkg::speed_24m: fract_step = ql_cfg_pkg::FRACT_BUS_24;
			default:               fract_step = ql_cfg_pkg::FRACT_BUS_FULL;
		endcase
	end

	// ==================================================
	// CPU bus phases
	// ==================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			cnt_bus  <= '0;
			bus_tick <= 1'b0;
			bus_pol  <= 1'b0;   // First tick goes to p
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
		end
		else
		begin
			{bus_tick, cnt_bus} <= {1'b0, cnt_bus} + fract_step;
			ce_bus_p <= bus_tick && !bus_pol;
			ce_bus_n <= bus_tick && bus_pol;
			bus_pol  <= bus_pol ^ bus_tick;   // Flip per tick
		end
	end

	// Integer dividers, tick on count zero
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			div_131k <= '0;
			div_vid  <= '0;
			ce_131k  <= 1'b0;
			ce_vid   <= 1'b0;
		end
		else
		begin
			div_131k <= (div_131k == DIV131_W'(ql_cfg_pkg::DIV_131K - 1)) ?
			            '0 : div_131k + DIV131_W'(1);
			div_vid  <= (div_vid == DIVVID_W'(ql_cfg_pkg::DIV_VID - 1)) ?
			            '0 : div_vid + DIVVID_W'(1);
			ce_131k  <= (div_131k == '0);
			ce_vid   <= (div_vid == '0);
		end
	end

	// Slow tick lands on a pixel tick, both dividers start together
	a_div_align: assert property (@(posedge clk_sys) disable iff (reset)
		ce_131k |-> ce_vid);

endmodule

// ==== design/ql_reset_ctrl.sv ====
// Hold time scales with CPU speed since it counts bus enables; RAM size needs a reset to change
module ql_reset_ctrl
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce_bus_p,
	input  ql_cfg_pkg::ram_cfg_e ram_cfg_sel,
	output logic                 core_reset,
	output ql_cfg_pkg::ram_cfg_e ram_cfg
);

	localparam int HOLD_W = $clog2(ql_cfg_pkg::RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;

	// Reload on reset, count down on phi1
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			hold_cnt <= HOLD_W'(ql_cfg_pkg::RESET_HOLD);
		else if (ce_bus_p && hold_cnt != '0)
			hold_cnt <= hold_cnt - HOLD_W'(1);
	end

	assign core_reset = (hold_cnt != '0);

	// RAM size follows the menu only while the core is held
	always_ff @(posedge clk_sys)
	begin
		if (core_reset)
			ram_cfg <= ram_cfg_sel;
	end

	// Once released the core stays running until the next reset
	a_hold_done: assert property (@(posedge clk_sys)
		(!reset && !core_reset) |=> !core_reset);

endmodule

// ==== design/ql_addr_decode.sv ====
// Pure combinational decode; outputs follow the cycle inputs and stay valid while they are held
module ql_addr_decode
(
	input  ql_bus_pkg::cpu_cycle_t cpu,
	input  ql_cfg_pkg::ram_cfg_e   ram_cfg,
	input  logic                   rom_shadow,
	output ql_bus_pkg::region_t    region,
	output ql_bus_pkg::mem_req_t   req
);

	logic        gc_en;          // (Super)GoldCard map
	logic [23:0] addr_mask;
	logic [23:0] addr;           // Masked byte address
	logic        cpu_rd;
	logic        cpu_wr;
	logic        bram;
	logic        xram;
	logic        gc_ram1;
	logic        gc_ram2;
	logic        gc_io;
	logic        rom;
	logic        ext_rom;
	logic        shadow_rd;
	logic        shadow_wr;

	assign gc_en = (ram_cfg == ql_cfg_pkg::ram_4096k);

	// Wrap per RAM size
	always_comb
	begin
		case (ram_cfg)
			ql_cfg_pkg::ram_128k: addr_mask = ql_cfg_pkg::MASK_256K;
			ql_cfg_pkg::ram_640k,
			ql_cfg_pkg::ram_896k: addr_mask = ql_cfg_pkg::MASK_1M;
			default:              addr_mask = ql_cfg_pkg::MASK_8M;
		endcase
	end

	// A0 rebuilt from the strobes, odd only for a lone low byte
	assign addr = {cpu.addr, !cpu.uds && cpu.lds} & addr_mask;

	assign cpu_rd = cpu.as &&  cpu.rw && (cpu.uds || cpu.lds);
	assign cpu_wr = cpu.as && !cpu.rw && (cpu.uds || cpu.lds);

	// ==================================================
	// Regions
	// ==================================================
	assign bram    = addr[23:17] == 7'h01;                           // $20000-$3ffff
	assign xram    = (ram_cfg == ql_cfg_pkg::ram_640k && addr[23:20] == 4'h0 && ^addr[19:18]) ||
	                 (ram_cfg == ql_cfg_pkg::ram_896k && addr[23:20] == 4'h0 && |addr[19:18]) ||
	                 (gc_en && addr[23:22] == 2'b00 && |addr[21:18]);  // Up to $3fffff
	assign gc_io   = gc_en && addr[23:8] == 16'h01c0;                // $1c000-$1c0ff
	assign gc_ram1 = gc_en && addr[23:15] == 9'h002;                 // $10000-$17fff
	assign gc_ram2 = gc_en && addr[23:14] == 10'h007 && !gc_io;      // $1c100-$1ffff
	assign rom     = addr[23:16] == 8'h00;
	assign ext_rom = addr[23:14] == 10'h003;                         // $c000-$ffff

	// Shadow RAM is filled while off and read back once on
	assign shadow_rd = cpu_rd && rom && !ext_rom && rom_shadow;
	assign shadow_wr = cpu_wr && rom && !ext_rom && !rom_shadow;

	always_comb
	begin
		region.rd          = cpu_rd;
		region.wr          = cpu_wr;
		region.ql_io       = addr[23:14] == 10'h006;                 // $18000-$1bfff
		region.ram         = bram || xram || gc_ram1 || gc_ram2;
		region.rom         = rom;
		region.os_rom      = rom && !ext_rom;
		region.ext_rom     = ext_rom;
		region.gc_io       = gc_io;
		region.gc_boot_rom = gc_en && addr[23:16] == 8'h04;
		region.gc_os_rom   = gc_en && addr[23:16] == 8'h40;
		region.addr        = addr;

		// Requests
		req.sdram_addr = {3'b000, addr[21:1]};                       // 4 MB of words
		req.sdram_wr   = cpu_wr && (region.ram || shadow_wr);
		req.sdram_oe   = cpu_rd && (region.ram || shadow_rd);
		req.vram_wr    = cpu_wr && addr[23:16] == 8'h02;
		req.zx8302_sel = (cpu_rd || cpu_wr) && region.ql_io && !addr[6];
		req.sdram_uds  = cpu.uds;
		req.sdram_lds  = cpu.lds;
	end

endmodule

// ==== design/ql_io_regs.sv ====
// Registers are write only; a held write cycle just reloads the same value each clock
module ql_io_regs
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::region_t    region,
	input  ql_bus_pkg::cpu_cycle_t cpu,
	output logic                   rom_shadow,
	output logic [7:0]             mc_stat
);

	logic gc_reg_wr;    // Upper byte write into GoldCard I/O
	logic vid_reg_wr;   // ZX8301 control at $18063

	assign gc_reg_wr  = region.gc_io && region.wr && cpu.uds && !cpu.lds;
	assign vid_reg_wr = region.ql_io && region.wr && cpu.lds &&
	                    {region.addr[6:5], region.addr[1]} == 3'b111;

	// ==================================================
	// GoldCard shadow RAM switch
	// ==================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rom_shadow <= 1'b0;   // Boot ROM mapping
		else if (gc_reg_wr)
		begin
			if (region.addr[7:0] == ql_cfg_pkg::GC_SHADOW_ON_OFS)
				rom_shadow <= 1'b1;
			else if (region.addr[7:0] == ql_cfg_pkg::GC_SHADOW_OFF_OFS)
				rom_shadow <= 1'b0;
		end
	end

	// Display mode, screen bank and blank bits
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			mc_stat <= 8'h00;
		else if (vid_reg_wr)
			mc_stat <= cpu.wdata[7:0];   // Low byte lane
	end

endmodule

// ==== design/ql_data_mux.sv ====
// Read data is valid only for the decoded region; dtack stays high outside RAM and shadow cycles
module ql_data_mux
(
	input  ql_bus_pkg::region_t  region,
	input  logic                 rom_shadow,
	input  ql_cfg_pkg::ram_cfg_e ram_cfg,
	input  ql_bus_pkg::mem_rsp_t mem,
	output logic [15:0]          cpu_din,
	output logic                 cpu_dtack
);

	logic        gc_en;
	logic        shadow_rd;
	logic        shadow_wr;
	logic [15:0] ql_dout;          // Plain QL map
	logic [15:0] gc_dout_boot;     // GoldCard, shadow off
	logic [15:0] gc_dout_shadow;   // GoldCard, shadow on

	assign gc_en     = (ram_cfg == ql_cfg_pkg::ram_4096k);
	assign shadow_rd = region.rd && region.os_rom && rom_shadow;
	assign shadow_wr = region.wr && region.os_rom && !rom_shadow;

	// ==================================================
	// Read data per map
	// ==================================================
	always_comb
	begin
		if (region.rom)
			ql_dout = mem.ql_rom_dout;          // OS and extension ROM
		else if (region.ram)
			ql_dout = mem.sdram_dout;
		else
			ql_dout = ql_cfg_pkg::FILL_WORD;

		if (region.rom || region.gc_boot_rom)
			gc_dout_boot = mem.gc_rom_dout;     // Both boot ROM copies
		else if (region.gc_os_rom)
			gc_dout_boot = mem.ql_rom_dout;     // Original OS moved up
		else if (region.ram)
			gc_dout_boot = mem.sdram_dout;
		else
			gc_dout_boot = ql_cfg_pkg::FILL_WORD;

		if (region.os_rom)
			gc_dout_shadow = mem.sdram_dout;    // OS copy now in RAM
		else if (region.ext_rom || region.gc_os_rom)
			gc_dout_shadow = mem.ql_rom_dout;
		else if (region.ram)
			gc_dout_shadow = mem.sdram_dout;
		else
			gc_dout_shadow = ql_cfg_pkg::FILL_WORD;
	end

	// I/O is mapped in every mode
	always_comb
	begin
		if (region.ql_io)
			cpu_din = mem.io_dout;
		else if (gc_en)
			cpu_din = rom_shadow ? gc_dout_shadow : gc_dout_boot;
		else
			cpu_din = ql_dout;
	end

	// SDRAM cycles wait for the controller, all else acks at once
	always_comb
	begin
		if (shadow_rd || shadow_wr || region.ram)
			cpu_dtack = mem.sdram_dtack;
		else
			cpu_dtack = 1'b1;
	end

endmodule

// ==== design/ql_bus_glue.sv ====
// Memories, CPU and peripherals sit outside; their data comes in on mem and requests leave on req
module ql_bus_glue
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_cfg_pkg::cpu_speed_e cpu_speed,
	input  ql_cfg_pkg::ram_cfg_e   ram_cfg_sel,
	input  ql_bus_pkg::cpu_cycle_t cpu,
	input  ql_bus_pkg::mem_rsp_t   mem,
	output logic                   core_reset,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid,
	output logic [15:0]            cpu_din,
	output logic                   cpu_dtack,
	output ql_bus_pkg::mem_req_t   req,
	output logic [7:0]             mc_stat
);

	ql_cfg_pkg::ram_cfg_e ram_cfg;       // Latched at reset
	ql_bus_pkg::region_t  region;
	logic                 rom_shadow;

	// ==================================================
	// Clocking and reset
	// ==================================================
	ql_clock_enables ql_clock_enables_i
	(
		.clk_sys   ( clk_sys   ),
		.reset     ( reset     ),
		.cpu_speed ( cpu_speed ),
		.ce_bus_p  ( ce_bus_p  ),
		.ce_bus_n  ( ce_bus_n  ),
		.ce_131k   ( ce_131k   ),
		.ce_vid    ( ce_vid    )
	);

	ql_reset_ctrl ql_reset_ctrl_i
	(
		.clk_sys     ( clk_sys     ),
		.reset       ( reset       ),
		.ce_bus_p    ( ce_bus_p    ),
		.ram_cfg_sel ( ram_cfg_sel ),
		.core_reset  ( core_reset  ),
		.ram_cfg     ( ram_cfg     )
	);

	// Bus path
	ql_addr_decode ql_addr_decode_i
	(
		.cpu        ( cpu        ),
		.ram_cfg    ( ram_cfg    ),
		.rom_shadow ( rom_shadow ),
		.region     ( region     ),
		.req        ( req        )
	);

	ql_io_regs ql_io_regs_i
	(
		.clk_sys    ( clk_sys    ),
		.reset      ( reset      ),
		.region     ( region     ),
		.cpu        ( cpu        ),
		.rom_shadow ( rom_shadow ),
		.mc_stat    ( mc_stat    )
	);

	ql_data_mux ql_data_mux_i
	(
		.region     ( region     ),
		.rom_shadow ( rom_shadow ),
		.ram_cfg    ( ram_cfg    ),
		.mem        ( mem        ),
		.cpu_din    ( cpu_din    ),
		.cpu_dtack  ( cpu_dtack  )
	);

endmodule

// ==== test/ql_tb_tasks.svh ====
// Included inside tb_ql_bus_glue; tasks rely on its signals, clock and check tasks
// ==================================================
// Reset and memory model helpers
// ==================================================

// Two cycle reset, then wait for the stretched core reset to end
task automatic reset_dut(input ql_cfg_pkg::ram_cfg_e cfg, input ql_cfg_pkg::cpu_speed_e speed,
                         output int p_count);
	int cycles;
	p_count = 0;
	cycles  = 0;
	@(posedge clk_sys);
	ram_cfg_sel <= cfg;
	cpu_speed   <= speed;
	reset       <= 1'b1;
	@(posedge clk_sys);
	@(negedge clk_sys);
	check_value("reset core_reset", 32'd1, 32'(core_reset));
	check_value("reset enables", 32'd0, 32'({ce_bus_p, ce_bus_n, ce_131k, ce_vid}));
	check_value("reset mc_stat", 32'd0, 32'(mc_stat));
	@(posedge clk_sys);
	reset <= 1'b0;
	@(negedge clk_sys);
	while (core_reset)
	begin
		if (ce_bus_n && p_count == 0)
			fail_run("reset_dut: first bus tick after reset came on ce_bus_n");
		if (ce_bus_p)
			p_count++;                       // Consumed by the hold counter next edge
		if (cycles == RESET_TIMEOUT)
			fail_run("reset_dut: core_reset never fell after reset");
		@(negedge clk_sys);
		cycles++;
	end
endtask

// Fresh random read data on every source, SDRAM ready
task automatic load_mem_data();
	@(posedge clk_sys);
	mem.sdram_dout  <= 16'($urandom());
	mem.ql_rom_dout <= 16'($urandom());
	mem.gc_rom_dout <= 16'($urandom());
	mem.io_dout     <= 16'($urandom());
	mem.sdram_dtack <= 1'b1;
endtask

// ==================================================
// Bus cycle helpers
// ==================================================
task automatic start_cycle(input logic rw, input logic uds, input logic lds,
                           input logic [23:0] byte_addr, input logic [15:0] wdata);
	@(posedge clk_sys);
	cpu.as    <= 1'b1;
	cpu.rw    <= rw;
	cpu.uds   <= uds;
	cpu.lds   <= lds;
	cpu.addr  <= byte_addr[23:1];            // A0 comes from the strobes
	cpu.wdata <= wdata;
	@(negedge clk_sys);
endtask

// Hold the cycle until dtack, then release the strobes
task automatic finish_cycle(input string test, output logic [15:0] rdata);
	int waited;
	waited = 0;
	while (!cpu_dtack)
	begin
		if (waited == DTACK_TIMEOUT)
			fail_run({test, ": cpu_dtack never came"});
		@(negedge clk_sys);
		waited++;
	end
	rdata = cpu_din;
	@(posedge clk_sys);
	cpu.as  <= 1'b0;                         // Write lands on this edge
	cpu.uds <= 1'b0;
	cpu.lds <= 1'b0;
endtask

task automatic bus_read(input string test, input logic [23:0] byte_addr,
                        output logic [15:0] rdata);
	start_cycle(1'b1, 1'b1, 1'b1, byte_addr, 16'h0000);
	finish_cycle(test, rdata);
endtask

task automatic bus_write(input string test, input logic uds, input logic lds,
                         input logic [23:0] byte_addr, input logic [15:0] wdata);
	logic [15:0] unused_rd;
	start_cycle(1'b0, uds, lds, byte_addr, wdata);
	finish_cycle(test, unused_rd);
endtask

// ==================================================
// Directed tests
// ==================================================
task automatic test_enables();
	int p_count;
	int ticks;
	int vid_count;
	int k131_count;
	int lo;
	bit seen;
	bit last_p;
	reset_dut(ql_cfg_pkg::ram_128k, ql_cfg_pkg::speed_ql, p_count);
	check_value("enables reset_hold", 32'(ql_cfg_pkg::RESET_HOLD), 32'(p_count));
	ticks      = 0;
	vid_count  = 0;
	k131_count = 0;
	seen       = 1'b0;
	last_p     = 1'b0;
	for (int i = 0; i < WINDOW; i++)
	begin
		@(negedge clk_sys);
		vid_count  += int'(ce_vid);
		k131_count += int'(ce_131k);
		if (ce_bus_p || ce_bus_n)
		begin
			if (seen && ce_bus_p == last_p)    // Same phase twice in a row
				fail_run("enables: ce_bus_p and ce_bus_n do not alternate");
			seen   = 1'b1;
			last_p = ce_bus_p;
			ticks++;
		end
	end
	check_value("enables ce_vid", 32'(WINDOW / int'(ql_cfg_pkg::DIV_VID)), 32'(vid_count));
	check_value("enables ce_131k", 32'(WINDOW / int'(ql_cfg_pkg::DIV_131K)), 32'(k131_count));
	// Carry rate is step / 2^FRACT_WIDTH per clock
	lo = (WINDOW * int'(ql_cfg_pkg::FRACT_BUS_QL)) / (1 << ql_cfg_pkg::FRACT_WIDTH);
	if (ticks < lo || ticks > lo + 1)
		fail_run($sformatf("enables speed_ql: expected %0d..%0d bus ticks, actual %0d",
		                   lo, lo + 1, ticks));
	// Full speed ticks on every clock
	reset_dut(ql_cfg_pkg::ram_128k, ql_cfg_pkg::speed_full, p_count);
	for (int i = 0; i < 64; i++)
	begin
		@(negedge clk_sys);
		check_value("enables speed_full", 32'd1, 32'(ce_bus_p || ce_bus_n));
	end
endtask

task automatic test_ql_map();
	int p_count;
	logic [15:0] rdata;
	reset_dut(ql_cfg_pkg::ram_128k, ql_cfg_pkg::speed_full, p_count);
	load_mem_data();
	bus_read("ql_map rom", 24'h000100, rdata);
	check_value("ql_map rom", 32'(mem.ql_rom_dout), 32'(rdata));
	// Stalled SDRAM holds off dtack
	@(posedge clk_sys);
	mem.sdram_dtack <= 1'b0;
	start_cycle(1'b1, 1'b1, 1'b1, 24'h020000, 16'h0000);
	repeat (3)
	begin
		check_value("ql_map ram oe", 32'd1, 32'(req.sdram_oe));
		check_value("ql_map ram stall", 32'd0, 32'(cpu_dtack));
		@(negedge clk_sys);
	end
	@(posedge clk_sys);
	mem.sdram_dtack <= 1'b1;
	@(negedge clk_sys);
	finish_cycle("ql_map ram", rdata);
	check_value("ql_map ram", 32'(mem.sdram_dout), 32'(rdata));
	// $60000 wraps at 256 KB onto $20000, word address $10000
	start_cycle(1'b1, 1'b1, 1'b1, 24'h060000, 16'h0000);
	check_value("ql_map wrap addr", 32'h010000, 32'(req.sdram_addr));
	finish_cycle("ql_map wrap", rdata);
	check_value("ql_map wrap", 32'(mem.sdram_dout), 32'(rdata));
	bus_read("ql_map unmapped", 24'h010000, rdata);
	check_value("ql_map unmapped", 32'(ql_cfg_pkg::FILL_WORD), 32'(rdata));
endtask

task automatic test_ext_ram();
	int p_count;
	logic [15:0] rdata;
	reset_dut(ql_cfg_pkg::ram_640k, ql_cfg_pkg::speed_full, p_count);
	load_mem_data();
	bus_read("ext_ram 640k $80000", 24'h080000, rdata);
	check_value("ext_ram 640k $80000", 32'(mem.sdram_dout), 32'(rdata));
	bus_read("ext_ram 640k $c0000", 24'h0c0000, rdata);
	check_value("ext_ram 640k $c0000", 32'(ql_cfg_pkg::FILL_WORD), 32'(rdata));
	reset_dut(ql_cfg_pkg::ram_896k, ql_cfg_pkg::speed_full, p_count);
	load_mem_data();
	bus_read("ext_ram 896k $c0000", 24'h0c0000, rdata);
	check_value("ext_ram 896k $c0000", 32'(mem.sdram_dout), 32'(rdata));
	// New size select without reset, map stays at 896k
	@(posedge clk_sys);
	ram_cfg_sel <= ql_cfg_pkg::ram_640k;
	repeat (4) @(posedge clk_sys);
	bus_read("ext_ram no reset", 24'h0c0000, rdata);
	check_value("ext_ram no reset", 32'(mem.sdram_dout), 32'(rdata));
endtask

task automatic test_goldcard();
	int p_count;
	logic [15:0] rdata;
	reset_dut(ql_cfg_pkg::ram_4096k, ql_cfg_pkg::speed_full, p_count);
	load_mem_data();
	bus_read("gc boot $000000", 24'h000000, rdata);
	check_value("gc boot $000000", 32'(mem.gc_rom_dout), 32'(rdata));
	bus_read("gc boot $040000", 24'h040000, rdata);
	check_value("gc boot $040000", 32'(mem.gc_rom_dout), 32'(rdata));
	bus_read("gc boot $400000", 24'h400000, rdata);
	check_value("gc boot $400000", 32'(mem.ql_rom_dout), 32'(rdata));
	// Shadow fill write goes to SDRAM
	start_cycle(1'b0, 1'b1, 1'b1, 24'h000200, 16'($urandom()));
	check_value("gc shadow fill wr", 32'd1, 32'(req.sdram_wr));
	finish_cycle("gc shadow fill", rdata);
	bus_write("gc shadow on", 1'b1, 1'b0, 24'h01c060, 16'h0000);
	start_cycle(1'b1, 1'b1, 1'b1, 24'h000200, 16'h0000);
	check_value("gc shadow oe", 32'd1, 32'(req.sdram_oe));
	finish_cycle("gc shadow os", rdata);
	check_value("gc shadow os", 32'(mem.sdram_dout), 32'(rdata));
	bus_read("gc shadow ext", 24'h00c000, rdata);
	check_value("gc shadow ext", 32'(mem.ql_rom_dout), 32'(rdata));
	bus_write("gc shadow off", 1'b1, 1'b0, 24'h01c064, 16'h0000);
	bus_read("gc boot again", 24'h000000, rdata);
	check_value("gc boot again", 32'(mem.gc_rom_dout), 32'(rdata));
endtask

task automatic test_io();
	int p_count;
	logic [15:0] wdata;
	logic [15:0] rdata;
	reset_dut(ql_cfg_pkg::ram_128k, ql_cfg_pkg::speed_full, p_count);
	load_mem_data();
	wdata = 16'($urandom());
	bus_write("io mc_stat", 1'b0, 1'b1, 24'h018063, wdata);   // Low byte lane only
	@(negedge clk_sys);
	check_value("io mc_stat", 32'(wdata[7:0]), 32'(mc_stat));
	reset_dut(ql_cfg_pkg::ram_128k, ql_cfg_pkg::speed_full, p_count);
	check_value("io mc_stat reset", 32'd0, 32'(mc_stat));
	load_mem_data();
	start_cycle(1'b1, 1'b1, 1'b1, 24'h018000, 16'h0000);
	check_value("io zx8302_sel", 32'd1, 32'(req.zx8302_sel));
	finish_cycle("io read", rdata);
	check_value("io read", 32'(mem.io_dout), 32'(rdata));
	// Odd byte into screen RAM, only the low lane reaches SDRAM
	start_cycle(1'b0, 1'b0, 1'b1, 24'h028001, 16'($urandom()));
	check_value("io vram_wr", 32'd1, 32'(req.vram_wr));
	check_value("io vram sdram_wr", 32'd1, 32'(req.sdram_wr));
	check_value("io vram byte lanes", 32'b01, 32'({req.sdram_uds, req.sdram_lds}));
	finish_cycle("io vram", rdata);
endtask

// ==== test/tb_ql_bus_glue.sv ====
// Runs on Verilator with timing; all DUT inputs change on rising edges and are sampled on falling
module tb_ql_bus_glue;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DTACK_TIMEOUT = 32;       // Cycles a bus cycle may wait for dtack
	localparam int RESET_TIMEOUT = 100000;   // Covers RESET_HOLD at the slowest bus rate
	localparam int WINDOW        = 6400;     // Enable count window, multiple of both dividers

	logic                   clk_sys;
	logic                   reset;
	ql_cfg_pkg::cpu_speed_e cpu_speed;
	ql_cfg_pkg::ram_cfg_e   ram_cfg_sel;
	ql_bus_pkg::cpu_cycle_t cpu;
	ql_bus_pkg::mem_rsp_t   mem;
	logic                   core_reset;
	logic                   ce_bus_p;
	logic                   ce_bus_n;
	logic                   ce_131k;
	logic                   ce_vid;
	logic [15:0]            cpu_din;
	logic                   cpu_dtack;
	ql_bus_pkg::mem_req_t   req;
	logic [7:0]             mc_stat;

	ql_bus_glue ql_bus_glue_i
	(
		.clk_sys     ( clk_sys     ),
		.reset       ( reset       ),
		.cpu_speed   ( cpu_speed   ),
		.ram_cfg_sel ( ram_cfg_sel ),
		.cpu         ( cpu         ),
		.mem         ( mem         ),
		.core_reset  ( core_reset  ),
		.ce_bus_p    ( ce_bus_p    ),
		.ce_bus_n    ( ce_bus_n    ),
		.ce_131k     ( ce_131k     ),
		.ce_vid      ( ce_vid      ),
		.cpu_din     ( cpu_din     ),
		.cpu_dtack   ( cpu_dtack   ),
		.req         ( req         ),
		.mc_stat     ( mc_stat     )
	);

	// 100 MHz nominal, period only matters relative to itself
	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Checking
	// ==================================================
	task automatic check_value(input string test, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Timeouts and protocol faults
	task automatic fail_run(input string reason);
		$display("[ERROR] %s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	`include "ql_tb_tasks.svh"

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin
		void'($urandom(32'hd7b1af53));      // One seed for the whole run
		reset       <= 1'b1;
		cpu_speed   <= ql_cfg_pkg::speed_full;
		ram_cfg_sel <= ql_cfg_pkg::ram_128k;
		cpu         <= '0;                   // Bus idle, no strobes
		mem         <= '0;
		test_enables();
		test_ql_map();
		test_ext_ram();
		test_goldcard();
		test_io();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+test
design/ql_cfg_pkg.sv
design/ql_bus_pkg.sv
design/ql_clock_enables.sv
design/ql_reset_ctrl.sv
design/ql_addr_decode.sv
design/ql_io_regs.sv
design/ql_data_mux.sv
design/ql_bus_glue.sv
test/tb_ql_bus_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the QL bus glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ql_bus_glue -f src.f -o sim_ql_bus_glue

./obj_dir/sim_ql_bus_glue
